// ==== logic/lbpPkg.sv ====
`default_nettype none

package lbpPkg;
  localparam int pixW    = 8;
  localparam int weightW = 16;
  localparam int fracW   = 16; // q16 fraction bits.
  localparam int accW    = 24;
  localparam int radiusW = 4;
  localparam int ringN   = 8;

  localparam int halfUnit = 1 << (fracW - 1); // 0.5 in q16.

  localparam int minRadius = 2;
  localparam int maxRadius = 8;

  localparam int interpLatency = 3;
  localparam int lbpLatency    = 5; // decode + execute + result.

  localparam int angle45  = 45;
  localparam int angle135 = 135;
  localparam int angle225 = 225;
  localparam int angle315 = 315;

  typedef logic [pixW-1:0] pixelT;
  typedef logic [3:0][pixW-1:0] quadT; // e, n, w, s or a, b, c, d.
  typedef quadT [3:0] cornerT; // 45, 135, 225, 315.
  typedef logic [accW-1:0] accT;
  typedef logic [ringN-1:0][accW-1:0] ringT;

  // weights as seen from the 45 degree point.
  typedef struct packed {
    logic [weightW-1:0] wSide;
    logic [weightW-1:0] wToward;
    logic [weightW-1:0] wAway;
  } weightSet;

  localparam weightSet weightTable [minRadius:maxRadius] = '{
    '{16'h3E1D, 16'h57D8, 16'h2BEC},
    '{16'h1B4A, 16'hC5A6, 16'h03C4},
    '{16'h2463, 16'h0789, 16'hAFB0},
    '{16'h3FAD, 16'h3739, 16'h496B},
    '{16'h2F0B, 16'h92D6, 16'h0F12},
    '{16'h0C37, 16'h00A5, 16'hE6EA},
    '{16'h39B3, 16'h1E24, 16'h6E73}
  };
endpackage

`default_nettype wire

// ==== logic/lbpIf.sv ====
`default_nettype none

// decode to execute.
interface sampleIf import lbpPkg::*; ();
  logic     valid;
  pixelT    center;
  quadT     axial;
  cornerT   corners;
  weightSet weights;

  modport producer (output valid, center, axial, corners, weights);
  modport consumer (input valid, center, axial, corners, weights);
endinterface

// execute to result.
interface pointIf import lbpPkg::*; ();
  logic  valid;
  pixelT center;
  ringT  samples; // q16, ring order from 0 degrees.

  modport producer (output valid, center, samples);
  modport consumer (input valid, center, samples);
endinterface

`default_nettype wire

// ==== logic/lbpDecode.sv ====
`default_nettype none

module lbpDecode import lbpPkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               inValid,
  input  logic [radiusW-1:0] radius,
  input  pixelT              center,
  input  quadT               axial,
  input  cornerT             corners,
  sampleIf.producer          sample
);
  weightSet lookup;
  logic     radiusOk;

  assign radiusOk = (radius >= minRadius) && (radius <= maxRadius);

  always_comb begin
    lookup = '0; // unsupported radius gives zero diagonals.
    if (radiusOk) begin
      lookup = weightTable[radius];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sample.valid   <= 1'b0;
      sample.center  <= '0;
      sample.axial   <= '0;
      sample.corners <= '0;
      sample.weights <= '0;
    end else begin
      sample.valid <= inValid;
      if (inValid) begin
        sample.center  <= center;
        sample.axial   <= axial;
        sample.corners <= corners;
        sample.weights <= lookup;
      end
    end
  end
endmodule

`default_nettype wire

// ==== logic/interpCalc.sv ====
`default_nettype none

module interpCalc import lbpPkg::*; #(
  parameter int angle = angle45
) (
  input  logic     clk,
  input  logic     rst_n,
  input  pixelT    a,
  input  pixelT    b,
  input  pixelT    c,
  input  pixelT    d,
  input  weightSet weights,
  output accT      sample
);
  logic [weightW-1:0] wA, wB, wC, wD;
  accT prodA, prodB, prodC, prodD;
  accT sumAB, sumCD;

  // rotate the 45 degree weight layout onto this angle's corners.
  always_comb begin
    case (angle)
      angle135: begin
        wA = weights.wAway;
        wB = weights.wSide;
        wC = weights.wSide;
        wD = weights.wToward;
      end
      angle225: begin
        wA = weights.wSide;
        wB = weights.wAway;
        wC = weights.wToward;
        wD = weights.wSide;
      end
      angle315: begin
        wA = weights.wToward;
        wB = weights.wSide;
        wC = weights.wSide;
        wD = weights.wAway;
      end
      default: begin
        wA = weights.wSide;
        wB = weights.wToward;
        wC = weights.wAway;
        wD = weights.wSide;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prodA  <= '0;
      prodB  <= '0;
      prodC  <= '0;
      prodD  <= '0;
      sumAB  <= '0;
      sumCD  <= '0;
      sample <= '0;
    end else begin
      prodA  <= wA * a; // 16x8 fits in 24 bits.
      prodB  <= wB * b;
      prodC  <= wC * c;
      prodD  <= wD * d;
      sumAB  <= prodA + prodB;
      sumCD  <= prodC + prodD;
      sample <= sumAB + sumCD; // wraps at 24 bits.
    end
  end
endmodule

`default_nettype wire

// ==== logic/lbpExecute.sv ====
`default_nettype none

module lbpExecute import lbpPkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  sampleIf.consumer sample,
  pointIf.producer  point
);
  localparam int diagAngle [4] = '{angle45, angle135, angle225, angle315};
  localparam int last = interpLatency - 1;

  accT   diag       [4];
  logic  validPipe  [interpLatency];
  pixelT centerPipe [interpLatency];
  quadT  axialPipe  [interpLatency];

  for (genvar g = 0; g < 4; g++) begin : gDiag
    interpCalc #(.angle(diagAngle[g])) uInterp (
      .clk     (clk),
      .rst_n   (rst_n),
      .a       (sample.corners[g][0]),
      .b       (sample.corners[g][1]),
      .c       (sample.corners[g][2]),
      .d       (sample.corners[g][3]),
      .weights (sample.weights),
      .sample  (diag[g])
    );
  end

  // keeps the whole pixels aligned with the interpolators.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < interpLatency; s++) begin
        validPipe[s]  <= 1'b0;
        centerPipe[s] <= '0;
        axialPipe[s]  <= '0;
      end
    end else begin
      validPipe[0]  <= sample.valid;
      centerPipe[0] <= sample.center;
      axialPipe[0]  <= sample.axial;
      for (int s = 1; s < interpLatency; s++) begin
        validPipe[s]  <= validPipe[s-1];
        centerPipe[s] <= centerPipe[s-1];
        axialPipe[s]  <= axialPipe[s-1];
      end
    end
  end

  always_comb begin
    point.valid  = validPipe[last];
    point.center = centerPipe[last];
    for (int k = 0; k < 4; k++) begin
      point.samples[2*k]   = {axialPipe[last][k], {fracW{1'b0}}}; // widen to q16.
      point.samples[2*k+1] = diag[k];
    end
  end
endmodule

`default_nettype wire

// ==== logic/lbpResult.sv ====
`default_nettype none

module lbpResult import lbpPkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  pointIf.consumer         point,
  output logic             outValid,
  output logic [ringN-1:0] lbpCode,
  output logic             uniform
);
  logic [accW:0]      biased  [ringN];
  pixelT              ringPix [ringN];
  logic [ringN-1:0]   code;
  logic [ringN-1:0]   edges;
  logic [3:0]         edgeCount;

  always_comb begin
    edgeCount = '0;
    for (int k = 0; k < ringN; k++) begin
      biased[k] = {1'b0, point.samples[k]} + (accW + 1)'(halfUnit);
      // saturate if rounding carried past 255.
      ringPix[k] = biased[k][accW] ? '1 : biased[k][accW-1:fracW];
      code[k] = ringPix[k] >= point.center;
    end
    edges = code ^ {code[0], code[ringN-1:1]}; // circular neighbour compare.
    for (int k = 0; k < ringN; k++) begin
      edgeCount = edgeCount + {3'b000, edges[k]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      outValid <= 1'b0;
      lbpCode  <= '0;
      uniform  <= 1'b0;
    end else begin
      outValid <= point.valid;
      if (point.valid) begin
        lbpCode <= code;
        uniform <= edgeCount <= 4'd2;
      end
    end
  end
endmodule

`default_nettype wire

// ==== logic/lbpTop.sv ====
`default_nettype none

module lbpTop import lbpPkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               inValid,
  input  logic [radiusW-1:0] radius,
  input  pixelT              center,
  input  quadT               axial,
  input  cornerT             corners,
  output logic               outValid,
  output logic [ringN-1:0]   lbpCode,
  output logic               uniform
);
  sampleIf sampleBus ();
  pointIf  pointBus ();

  lbpDecode uDecode (
    .clk     (clk),
    .rst_n   (rst_n),
    .inValid (inValid),
    .radius  (radius),
    .center  (center),
    .axial   (axial),
    .corners (corners),
    .sample  (sampleBus.producer)
  );

  lbpExecute uExecute (
    .clk    (clk),
    .rst_n  (rst_n),
    .sample (sampleBus.consumer),
    .point  (pointBus.producer)
  );

  lbpResult uResult (
    .clk      (clk),
    .rst_n    (rst_n),
    .point    (pointBus.consumer),
    .outValid (outValid),
    .lbpCode  (lbpCode),
    .uniform  (uniform)
  );
endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
`default_nettype none

module clockGen (
  output logic clk,
  output logic rst_n
);
  localparam int halfPeriod  = 50;
  localparam int resetCycles = 4;

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1; // released between edges.
  end
endmodule

`default_nettype wire

// ==== sim/lbp_asserts.sv ====
`default_nettype none

module lbp_asserts import lbpPkg::*; (
  input logic             clk,
  input logic             rst_n,
  input logic             inValid,
  input logic             outValid,
  input logic [ringN-1:0] lbpCode,
  input logic             uniform
);
  itemLeaves: assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(inValid, lbpLatency) |-> outValid
  ) else $error("accepted item gave no result after the pipeline depth");

  noStrayResult: assert property (
    @(posedge clk) disable iff (!rst_n)
    outValid |-> $past(inValid, lbpLatency)
  ) else $error("result without a matching input");

  resultKnown: assert property (
    @(posedge clk) disable iff (!rst_n)
    outValid |-> !$isunknown({lbpCode, uniform})
  ) else $error("unknown bits on lbpCode or uniform");
endmodule

bind lbpTop lbp_asserts uAsserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .inValid  (inValid),
  .outValid (outValid),
  .lbpCode  (lbpCode),
  .uniform  (uniform)
);

`default_nettype wire

// ==== sim/lbpTb.sv ====
`default_nettype none

module lbpTb import lbpPkg::*; ();
  localparam int randPerRadius = 6;
  localparam int streamCount   = 64;
  localparam int radiusCount   = maxRadius - minRadius + 1;
  localparam int drainCycles   = lbpLatency + 2;
  localparam int testCycles    = 8 + 2 * radiusCount + 4 * randPerRadius * radiusCount
                                 + streamCount + 2 * 2 * 9 + 2 * 8 + 6 * drainCycles;
  localparam int cycleLimit    = testCycles * 3 / 2 + lbpLatency;

  // weight role of corners a, b, c, d as 0 side, 1 toward or 2 away.
  localparam int cornerRole [4][4] = '{'{0, 1, 2, 0}, '{2, 0, 0, 1}, '{0, 2, 1, 0}, '{1, 0, 0, 2}};
  localparam logic [7:0] uniPattern [8] = '{8'h0F, 8'h3C, 8'h81, 8'hFE,
                                           8'h55, 8'h33, 8'h11, 8'h00};
  localparam logic [7:0] uniExpect = 8'b1000_1111; // one bit per pattern.

  logic               clk;
  logic               rst_n;
  logic               inValid;
  logic [radiusW-1:0] radius;
  pixelT              center;
  quadT               axial;
  cornerT             corners;
  logic               outValid;
  logic [ringN-1:0]   lbpCode;
  logic               uniform;

  logic [31:0] lfsr;
  logic [8:0]  expQ [$]; // {uniform, code}.
  int          dueQ [$];
  logic [8:0]  expected;
  int          dueCycle;
  int          cycleCount  = 0;
  int          checks      = 0;
  int          errors      = 0;
  int          driveErrors = 0;
  int          mark        = 0;

  clockGen uClock (.clk(clk), .rst_n(rst_n));

  lbpTop DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .inValid  (inValid),
    .radius   (radius),
    .center   (center),
    .axial    (axial),
    .corners  (corners),
    .outValid (outValid),
    .lbpCode  (lbpCode),
    .uniform  (uniform)
  );

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1.
  endfunction

  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [8:0] refLbp(input logic [radiusW-1:0] r, input pixelT cen,
                                        input quadT ax, input cornerT co);
    weightSet    ws;
    logic [15:0] wr [3];
    logic [23:0] ring [8];
    int unsigned rounded;
    logic [7:0]  code;
    pixelT       pix;
    int unsigned acc;
    int          changes;
    ws = '0;
    if (int'(r) >= minRadius && int'(r) <= maxRadius) begin
      ws = weightTable[r];
    end
    wr[0] = ws.wSide;
    wr[1] = ws.wToward;
    wr[2] = ws.wAway;
    for (int k = 0; k < 4; k++) begin
      acc = 0;
      for (int q = 0; q < 4; q++) begin
        acc = acc + 32'(wr[cornerRole[k][q]]) * 32'(co[k][q]);
      end
      ring[2*k]   = {ax[k], 16'h0000};
      ring[2*k+1] = acc[23:0]; // sum wraps at 24 bits.
    end
    for (int k = 0; k < 8; k++) begin
      rounded = (32'(ring[k]) + 32'd32768) / 32'd65536; // nearest whole pixel.
      pix = (rounded > 255) ? 8'hFF : rounded[7:0];
      code[k] = pix >= cen;
    end
    changes = 0;
    for (int k = 0; k < 8; k++) begin
      if (code[k] != code[(k+1)%8]) begin
        changes++;
      end
    end
    return {changes <= 2, code};
  endfunction

  task automatic randomPixels(output pixelT cen, output quadT ax, output cornerT co);
    logic [31:0] v;
    takeBits(8, v);
    cen = v[7:0];
    for (int k = 0; k < 4; k++) begin
      takeBits(8, v);
      ax[k] = v[7:0];
    end
    for (int g = 0; g < 4; g++) begin
      for (int q = 0; q < 4; q++) begin
        takeBits(8, v);
        co[g][q] = v[7:0];
      end
    end
  endtask

  task automatic send(input logic [radiusW-1:0] r, input pixelT cen, input quadT ax,
                      input cornerT co);
    radius  = r;
    center  = cen;
    axial   = ax;
    corners = co;
    inValid = 1'b1;
    expQ.push_back(refLbp(r, cen, ax, co));
    dueQ.push_back(cycleCount + lbpLatency);
    @(negedge clk);
  endtask

  task automatic idle(input int n);
    inValid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic drain();
    idle(drainCycles);
    if (expQ.size() != 0) begin
      $display("ERROR: %0d results never arrived", expQ.size());
      driveErrors++;
      expQ.delete();
      dueQ.delete();
    end
  endtask

  task automatic endTest(input string name);
    int now;
    now = errors + driveErrors;
    $display("test %s: %s, %0d errors", name, (now == mark) ? "passed" : "FAILED", now - mark);
    mark = now;
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  always @(negedge clk) begin
    if (cycleCount > 0) begin
      if (outValid === 1'b1) begin
        if (expQ.size() == 0) begin
          $display("ERROR: result at cycle %0d with no item in flight", cycleCount);
          errors++;
        end else begin
          expected = expQ.pop_front();
          dueCycle = dueQ.pop_front();
          checks++;
          if (lbpCode !== expected[7:0]) begin
            $display("MISMATCH lbpCode got %h expected %h", lbpCode, expected[7:0]);
            errors++;
          end
          if (uniform !== expected[8]) begin
            $display("MISMATCH uniform got %h expected %h", uniform, expected[8]);
            errors++;
          end
          if (cycleCount != dueCycle) begin
            $display("ERROR: result came at cycle %0d, due at %0d", cycleCount, dueCycle);
            errors++;
          end
        end
      end else if (outValid !== 1'b0) begin
        $display("ERROR: outValid is unknown at cycle %0d", cycleCount);
        errors++;
      end
    end
  end

  initial begin
    wait (cycleCount >= cycleLimit);
    $display("ERROR: timeout after %0d cycles", cycleLimit);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [31:0] v;
    pixelT       cen;
    quadT        ax;
    cornerT      co;
    logic [7:0]  pat;
    logic [8:0]  want;
    inValid = 1'b0;
    radius  = '0;
    center  = '0;
    axial   = '0;
    corners = '0;
    lfsr    = 32'h0918_5b53;

    @(posedge rst_n);
    idle(4); // outValid must stay low here.
    drain();
    endTest("reset");

    for (int r = minRadius; r <= maxRadius; r++) begin
      takeBits(8, v);
      send(radiusW'(r), v[7:0], {4{v[7:0]}}, {16{v[7:0]}});
      idle(1);
    end
    drain();
    endTest("flat");

    for (int r = minRadius; r <= maxRadius; r++) begin
      for (int i = 0; i < randPerRadius; i++) begin
        randomPixels(cen, ax, co);
        send(radiusW'(r), cen, ax, co);
        takeBits(2, v);
        idle(int'(v[1:0]));
      end
    end
    drain();
    endTest("random");

    for (int i = 0; i < streamCount; i++) begin
      takeBits(3, v);
      randomPixels(cen, ax, co);
      send(radiusW'(minRadius + int'(v[2:0]) % radiusCount), cen, ax, co);
    end
    drain();
    endTest("stream");

    for (int r = 0; r < 16; r++) begin
      if (r < minRadius || r > maxRadius) begin
        for (int i = 0; i < 2; i++) begin
          randomPixels(cen, ax, co);
          send(radiusW'(r), cen, ax, co);
          idle(1);
        end
      end
    end
    drain();
    endTest("badRadius");

    for (int p = 0; p < 8; p++) begin
      pat = uniPattern[p];
      for (int k = 0; k < 4; k++) begin
        ax[k] = pat[2*k] ? 8'd150 : 8'd50;
        co[k] = {4{pat[2*k+1] ? 8'd150 : 8'd50}};
      end
      want = refLbp(4'd2, 8'd100, ax, co);
      if (want[7:0] != pat || want[8] != uniExpect[p]) begin
        $display("ERROR: reference gives code %h uniform %h for pattern %h",
                 want[7:0], want[8], pat);
        driveErrors++;
      end
      send(4'd2, 8'd100, ax, co);
      idle(1);
    end
    drain();
    endTest("uniform");

    $display("%0d checks, %0d errors", checks, errors + driveErrors);
    if (errors + driveErrors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end
endmodule

`default_nettype wire

// ==== list.f ====
logic/lbpPkg.sv
logic/lbpIf.sv
logic/lbpDecode.sv
logic/interpCalc.sv
logic/lbpExecute.sv
logic/lbpResult.sv
logic/lbpTop.sv
sim/clockGen.sv
sim/lbp_asserts.sv
sim/lbpTb.sv

// ==== Makefile ====
BIN  = obj_dir/VlbpTb
SRCS = $(shell grep -v '^+' list.f)

.PHONY: all run clean

all: $(BIN)

$(BIN): list.f $(SRCS)
	verilator --binary --assert --top-module lbpTb -f list.f

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
